// ==== filelist.f ====
+incdir+sim
rtl/activeListPkg.sv
rtl/alPointers.sv
rtl/alStorage.sv
rtl/faultTracker.sv
rtl/commitView.sv
rtl/activeList.sv
sim/activeListTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = activeListTb
FILELIST  = filelist.f
OBJDIR    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== sim/alTbUtil.svh ====
// ==========================================================================
// Active list testbench helpers
// LFSR stimulus source and typed compare tasks for the DUT outputs
// ==========================================================================
`ifndef AL_TB_UTIL_SVH
`define AL_TB_UTIL_SVH

logic [31:0] lfsrState = 32'h1fb7_21d4;

// Galois LFSR stepped once per bit taken
function automatic logic lfsrBit();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) begin
        lfsrState ^= 32'hA300_0000;
    end
    return outBit;
endfunction

function automatic logic [31:0] randBits(input int num);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < num; i++) begin
        value = {value[30:0], lfsrBit()};
    end
    return value;
endfunction

task automatic mismatchStop(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("** Error: %s is %h, expected %h", name, got, exp);
    $display("Test failed");
    $fatal(1, "Output value mismatch");
endtask

task automatic pcCheck(input string name, input activeListPkg::pcT got, exp);
    if (got !== exp) mismatchStop(name, 64'(got), 64'(exp));
endtask

task automatic entryCheck(input string name, input activeListPkg::alEntryT got, exp);
    if (got !== exp) mismatchStop(name, 64'(got), 64'(exp));
endtask

task automatic stateCheck(input string name, input activeListPkg::execStateT got, exp);
    if (got !== exp) mismatchStop(name, 64'(got), 64'(exp));
endtask

task automatic countCheck(input string name, input activeListPkg::alCountT got, exp);
    if (got !== exp) mismatchStop(name, 64'(got), 64'(exp));
endtask

task automatic refetchCheck(input string name, input activeListPkg::refetchT got, exp);
    if (got !== exp) mismatchStop(name, 64'(got), 64'(exp));
endtask

task automatic indexCheck(input string name, input activeListPkg::alIndexT got, exp);
    if (got !== exp) mismatchStop(name, 64'(got), 64'(exp));
endtask

task automatic flagCheck(input string name, input logic got, exp);
    if (got !== exp) mismatchStop(name, 64'(got), 64'(exp));
endtask

`endif

// ==== sim/activeListTb.sv ====
// ==========================================================================
// Active list testbench
// Table driven run against a small reference model of the reorder buffer
// ==========================================================================
module activeListTb;

    localparam int resetCycles = 10;
    localparam int rw = activeListPkg::alRenameWidth;
    localparam int cw = activeListPkg::alCommitWidth;
    localparam int iw = activeListPkg::alIssueWidth;
    localparam int entryNum = activeListPkg::alEntryNum;

    // Inputs of one cycle plus the outputs expected during that cycle
    typedef struct packed {
        logic [rw-1:0]                     push;
        activeListPkg::alEntryT [rw-1:0]   data;
        logic [iw-1:0]                     cv;
        activeListPkg::completionT [iw-1:0] cd;
        activeListPkg::laneCountT          pop;
        logic                              toRec;
        logic                              unable;
        activeListPkg::alIndexT            fHead;
        activeListPkg::alIndexT            fTail;
        activeListPkg::alIndexT [rw-1:0]   expTailPtr;
        logic                              expDet;
        activeListPkg::refetchT            expRef;
        activeListPkg::pcT                 expPcWb;
        logic                              expFlushAll;
        activeListPkg::alCountT            expCount;
        activeListPkg::alEntryT [cw-1:0]   expHead;
        activeListPkg::execStateT [cw-1:0] expState;
        activeListPkg::faultRecT           expRec;
        activeListPkg::alCountT            expRecNum;
    } stepT;

    logic clk;
    logic rstN;
    logic [rw-1:0] pushTail;
    activeListPkg::alEntryT pushData [rw];
    logic [iw-1:0] completeValid;
    activeListPkg::completionT completeData [iw];
    activeListPkg::laneCountT popHeadNum;
    logic toRecoveryPhase;
    logic unableToStartRecovery;
    activeListPkg::alIndexT flushRangeHeadPtr;
    activeListPkg::alIndexT flushRangeTailPtr;
    logic allocatable;
    logic empty;
    activeListPkg::alCountT validEntryNum;
    activeListPkg::alIndexT pushedTailPtr [rw];
    activeListPkg::alEntryT headData [cw];
    activeListPkg::execStateT headExecState [cw];
    logic exceptionDetected;
    activeListPkg::refetchT refetchType;
    activeListPkg::pcT recoveredPcCommit;
    activeListPkg::pcT recoveredPcWb;
    activeListPkg::alIndexT exceptionOpPtr;
    logic flushAllInsns;
    activeListPkg::alCountT recoveryEntryNum;

    stepT steps[$];
    // Reference model state
    int mHead = 0;
    int mTail = 0;
    int mCount = 0;
    activeListPkg::alEntryT mEntry [entryNum];
    logic mDone [entryNum];
    activeListPkg::faultRecT mRec = '0;
    activeListPkg::alCountT mRecNum = '0;
    int cycleCount = 0;
    int cycleLimit = 100000;

    `include "alTbUtil.svh"

    activeList dut (.*);

    function automatic activeListPkg::completionT makeCompletion(input int offset,
            input activeListPkg::execStateT state, input logic isBranch, input logic isStore);
        activeListPkg::completionT c;
        c.ptr = activeListPkg::alIndexT'((mHead + offset) % entryNum);
        c.pc = mEntry[c.ptr].pc;
        c.state = state;
        c.isBranch = isBranch;
        c.isStore = isStore;
        return c;
    endfunction

    // Fills in the expected outputs, then advances the model by one cycle
    task automatic addStep(input stepT sIn);
        stepT s;
        activeListPkg::faultRecT cand;
        activeListPkg::alIndexT ptr;
        activeListPkg::execStateT st;
        int oldestAge;
        int laneAge;
        int pushNum;
        logic hit;
        logic atCommit;
        s = sIn;
        s.expCount = activeListPkg::alCountT'(mCount);
        s.expRec = mRec;
        s.expRecNum = mRecNum;
        for (int i = 0; i < cw; i++) begin
            ptr = activeListPkg::alIndexT'((mHead + i) % entryNum);
            s.expHead[i] = mEntry[ptr];
            if (mRec.valid && mRec.ptr == ptr) s.expState[i] = mRec.state;
            else if (mDone[ptr] === 1'b1) s.expState[i] = activeListPkg::ExecSuccess;
            else s.expState[i] = activeListPkg::ExecNotFinished;
        end
        cand = mRec;
        hit = 1'b0;
        atCommit = 1'b0;
        s.expRef = activeListPkg::RefetchThisPc;
        oldestAge = (int'(mRec.ptr) - mHead + entryNum) % entryNum;
        for (int i = 0; i < iw; i++) begin
            st = s.cd[i].state;
            laneAge = (int'(s.cd[i].ptr) - mHead + entryNum) % entryNum;
            if (s.cv[i] && st != activeListPkg::ExecNotFinished &&
                    st != activeListPkg::ExecSuccess && (!cand.valid || laneAge < oldestAge)) begin
                oldestAge = laneAge;
                cand.valid = 1'b1;
                cand.ptr = s.cd[i].ptr;
                cand.pc = s.cd[i].pc;
                cand.state = st;
                hit = st == activeListPkg::ExecRefetchThis || st == activeListPkg::ExecRefetchNext;
                atCommit = st == activeListPkg::ExecTrap || st == activeListPkg::ExecFault;
                if (st != activeListPkg::ExecRefetchNext) s.expRef = activeListPkg::RefetchThisPc;
                else if (s.cd[i].isBranch) s.expRef = activeListPkg::RefetchBranchTarget;
                else if (s.cd[i].isStore) s.expRef = activeListPkg::RefetchStoreNextPc;
                else s.expRef = activeListPkg::RefetchNextPc;
            end
        end
        s.expDet = hit && !s.unable;
        if (s.expDet) cand.state = activeListPkg::ExecSuccess;
        s.expPcWb = cand.pc;
        s.expFlushAll = s.fHead == s.fTail && mCount == entryNum;
        pushNum = 0;
        for (int i = 0; i < rw; i++) begin
            s.expTailPtr[i] = activeListPkg::alIndexT'((mTail + pushNum) % entryNum);
            if (s.push[i]) begin
                mEntry[s.expTailPtr[i]] = s.data[i];
                mDone[s.expTailPtr[i]] = 1'b0;
                pushNum++;
            end
        end
        for (int i = 0; i < iw; i++) begin
            if (s.cv[i]) mDone[s.cd[i].ptr] = s.cd[i].state != activeListPkg::ExecNotFinished;
        end
        if (s.toRec) begin
            mRecNum = s.expFlushAll ? activeListPkg::alCountT'(entryNum) :
                activeListPkg::alCountT'((int'(s.fTail) - int'(s.fHead) + entryNum) % entryNum);
        end
        mRec = (s.toRec && !s.expDet && !atCommit) ? '0 : cand;
        mHead = (mHead + int'(s.pop)) % entryNum;
        mTail = (mTail + pushNum) % entryNum;
        mCount = mCount + pushNum - int'(s.pop);
        steps.push_back(s);
    endtask

    task automatic checkOutputs(input stepT s);
        countCheck("validEntryNum", validEntryNum, s.expCount);
        flagCheck("empty", empty, s.expCount == 0);
        flagCheck("allocatable", allocatable, s.expCount <= entryNum - rw);
        countCheck("recoveryEntryNum", recoveryEntryNum, s.expRecNum);
        for (int i = 0; i < cw; i++) begin
            if (i < int'(s.expCount)) begin
                entryCheck($sformatf("headData[%0d]", i), headData[i], s.expHead[i]);
                stateCheck($sformatf("headExecState[%0d]", i), headExecState[i], s.expState[i]);
            end
        end
        for (int i = 0; i < rw; i++) begin
            if (s.push[i]) begin
                indexCheck($sformatf("pushedTailPtr[%0d]", i), pushedTailPtr[i], s.expTailPtr[i]);
            end
        end
        if (s.expRec.valid) begin
            pcCheck("recoveredPcCommit", recoveredPcCommit, s.expRec.pc);
            indexCheck("exceptionOpPtr", exceptionOpPtr, s.expRec.ptr);
        end
        flagCheck("exceptionDetected", exceptionDetected, s.expDet);
        refetchCheck("refetchType", refetchType, s.expRef);
        pcCheck("recoveredPcWb", recoveredPcWb, s.expPcWb);
        flagCheck("flushAllInsns", flushAllInsns, s.expFlushAll);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Test failed");
            $fatal(1, "Timeout, the step table did not finish within the cycle limit");
        end
    end

    initial begin
        stepT s;
        int lane;
        int pick;
        rstN = 1'b0;
        pushTail = '0;
        completeValid = '0;
        popHeadNum = '0;
        toRecoveryPhase = 1'b0;
        unableToStartRecovery = 1'b0;
        flushRangeHeadPtr = '0;
        flushRangeTailPtr = '0;
        for (int i = 0; i < rw; i++) pushData[i] = '0;
        for (int i = 0; i < iw; i++) completeData[i] = '0;

        // Random push, pop and completion traffic
        for (int k = 0; k < 60; k++) begin
            s = '0;
            if (mCount <= entryNum - rw && k < 48) s.push = 2'(randBits(2));
            for (int i = 0; i < rw; i++) begin
                s.data[i].pc = randBits(32);
                s.data[i].destReg = activeListPkg::regNumT'(randBits(5));
            end
            if (k >= 15) s.pop = activeListPkg::laneCountT'(int'(randBits(2)) % 3);
            if (int'(s.pop) > mCount) s.pop = activeListPkg::laneCountT'(mCount);
            if (mCount > 0 && randBits(1)) begin
                lane = int'(randBits(2)) % iw;
                pick = int'(randBits(4)) % mCount;
                s.cv[lane] = 1'b1;
                s.cd[lane] = makeCompletion(pick, activeListPkg::ExecSuccess, 1'b0, 1'b0);
            end
            if (randBits(3) == 0) begin
                s.toRec = 1'b1;
                s.fHead = activeListPkg::alIndexT'(randBits(4));
                s.fTail = (mCount == entryNum) ? s.fHead : activeListPkg::alIndexT'(randBits(4));
            end
            addStep(s);
        end

        // Fill to a full buffer with a lone lane 1 push at 13 entries
        while (mCount <= entryNum - rw) begin
            s = '0;
            s.push = (mCount == entryNum - 3) ? 2'b10 : 2'b11;
            for (int i = 0; i < rw; i++) s.data[i].pc = randBits(32);
            addStep(s);
        end
        s = '0;
        s.toRec = 1'b1;
        s.fHead = activeListPkg::alIndexT'(mHead);
        s.fTail = s.fHead;
        addStep(s);

        // Oldest fault by age within one cycle and across cycles
        s = '0;
        s.cv = 3'b111;
        s.cd[0] = makeCompletion(5, activeListPkg::ExecFault, 1'b0, 1'b0);
        s.cd[1] = makeCompletion(2, activeListPkg::ExecTrap, 1'b0, 1'b0);
        s.cd[2] = makeCompletion(2, activeListPkg::ExecFault, 1'b0, 1'b0);
        addStep(s);
        s = '0;
        s.cv = 3'b101;
        s.cd[0] = makeCompletion(4, activeListPkg::ExecFault, 1'b0, 1'b0);
        s.cd[2] = makeCompletion(0, activeListPkg::ExecTrap, 1'b0, 1'b0);
        addStep(s);
        addStep('0);

        // Refetch variants with a recovery step before each
        for (int v = 0; v < 7; v++) begin
            s = '0;
            s.toRec = 1'b1;
            s.fHead = activeListPkg::alIndexT'(randBits(4));
            s.fTail = activeListPkg::alIndexT'(randBits(4));
            addStep(s);
            if (v == 6) break;
            s = '0;
            s.cv[v % iw] = 1'b1;
            s.cd[v % iw] = makeCompletion((v >= 4) ? 0 : 1,
                (v == 3) ? activeListPkg::ExecRefetchThis : activeListPkg::ExecRefetchNext,
                v == 0, v <= 1);
            s.unable = v >= 4;
            s.toRec = v == 5;
            addStep(s);
        end

        // Drain while completing entries ahead of the head
        while (mCount > 0) begin
            s = '0;
            s.pop = (mCount >= 2) ? 2'd2 : 2'd1;
            s.cv = {1'b0, mCount > 3, mCount > 2};
            s.cd[0] = makeCompletion(2, activeListPkg::ExecSuccess, 1'b0, 1'b0);
            s.cd[1] = makeCompletion(3, activeListPkg::ExecSuccess, 1'b0, 1'b0);
            addStep(s);
        end
        addStep('0);

        cycleLimit = steps.size() + resetCycles + 20;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        foreach (steps[k]) begin
            @(posedge clk);
            pushTail <= steps[k].push;
            for (int i = 0; i < rw; i++) pushData[i] <= steps[k].data[i];
            completeValid <= steps[k].cv;
            for (int i = 0; i < iw; i++) completeData[i] <= steps[k].cd[i];
            popHeadNum <= steps[k].pop;
            toRecoveryPhase <= steps[k].toRec;
            unableToStartRecovery <= steps[k].unable;
            flushRangeHeadPtr <= steps[k].fHead;
            flushRangeTailPtr <= steps[k].fTail;
            // Registered and combinational outputs are settled by mid cycle
            @(negedge clk);
            checkOutputs(steps[k]);
        end
        $display("Test passed");
        $finish;
    end

endmodule

// ==== rtl/activeList.sv ====
// =========================================================================
// Active list
// Reorder buffer top tying together pointers, payload and done arrays,
// fault tracking and the commit side view
// =========================================================================
module activeList (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [activeListPkg::alRenameWidth-1:0] pushTail,
    input  activeListPkg::alEntryT        pushData [activeListPkg::alRenameWidth],
    input  logic [activeListPkg::alIssueWidth-1:0]  completeValid,
    input  activeListPkg::completionT     completeData [activeListPkg::alIssueWidth],
    input  activeListPkg::laneCountT      popHeadNum,
    input  logic                          toRecoveryPhase,
    input  logic                          unableToStartRecovery,
    input  activeListPkg::alIndexT        flushRangeHeadPtr,
    input  activeListPkg::alIndexT        flushRangeTailPtr,
    output logic                          allocatable,
    output logic                          empty,
    output activeListPkg::alCountT        validEntryNum,
    output activeListPkg::alIndexT        pushedTailPtr [activeListPkg::alRenameWidth],
    output activeListPkg::alEntryT        headData [activeListPkg::alCommitWidth],
    output activeListPkg::execStateT      headExecState [activeListPkg::alCommitWidth],
    output logic                          exceptionDetected,
    output activeListPkg::refetchT        refetchType,
    output activeListPkg::pcT             recoveredPcCommit,
    output activeListPkg::pcT             recoveredPcWb,
    output activeListPkg::alIndexT        exceptionOpPtr,
    output logic                          flushAllInsns,
    output activeListPkg::alCountT        recoveryEntryNum
);

    activeListPkg::alIndexT  headPtr;
    activeListPkg::alIndexT  headReadPtr [activeListPkg::alCommitWidth];
    activeListPkg::faultRecT faultRec;

    logic [activeListPkg::alDoneWriteNum-1:0] doneWe;
    activeListPkg::alIndexT doneAddr [activeListPkg::alDoneWriteNum];
    logic [0:0]             doneData [activeListPkg::alDoneWriteNum];
    logic [0:0]             doneRead [activeListPkg::alCommitWidth];

    alPointers pointers (
        .clk(clk), .rstN(rstN), .pushTail(pushTail), .popHeadNum(popHeadNum),
        .headPtr(headPtr), .pushedTailPtr(pushedTailPtr), .count(validEntryNum),
        .allocatable(allocatable), .empty(empty), .nextTailPtr()
    );

    alStorage #(
        .entryWidth($bits(activeListPkg::alEntryT)),
        .writeNum(activeListPkg::alRenameWidth)
    ) entryArray (
        .clk(clk), .writeEn(pushTail), .writeAddr(pushedTailPtr), .writeData(pushData),
        .readAddr(headReadPtr), .readData(headData)
    );

    always_comb begin
        // Dispatch clears the done bit and completion lanes set it
        for (int i = 0; i < activeListPkg::alRenameWidth; i++) begin
            doneWe[i]   = pushTail[i];
            doneAddr[i] = pushedTailPtr[i];
            doneData[i] = 1'b0;
        end
        for (int i = 0; i < activeListPkg::alIssueWidth; i++) begin
            doneWe[activeListPkg::alRenameWidth+i]   = completeValid[i];
            doneAddr[activeListPkg::alRenameWidth+i] = completeData[i].ptr;
            doneData[activeListPkg::alRenameWidth+i] =
                completeData[i].state != activeListPkg::ExecNotFinished;
        end
    end

    alStorage #(
        .entryWidth(1),
        .writeNum(activeListPkg::alDoneWriteNum)
    ) doneArray (
        .clk(clk), .writeEn(doneWe), .writeAddr(doneAddr), .writeData(doneData),
        .readAddr(headReadPtr), .readData(doneRead)
    );

    faultTracker tracker (
        .clk(clk), .rstN(rstN), .completeValid(completeValid), .completeData(completeData),
        .headPtr(headPtr), .toRecoveryPhase(toRecoveryPhase),
        .unableToStartRecovery(unableToStartRecovery), .faultRec(faultRec),
        .exceptionDetected(exceptionDetected), .refetchType(refetchType),
        .recoveredPcWb(recoveredPcWb)
    );

    commitView view (
        .clk(clk), .rstN(rstN), .headPtr(headPtr), .count(validEntryNum),
        .doneBits(doneRead), .faultRec(faultRec), .flushRangeHeadPtr(flushRangeHeadPtr),
        .flushRangeTailPtr(flushRangeTailPtr), .toRecoveryPhase(toRecoveryPhase),
        .headReadPtr(headReadPtr), .headExecState(headExecState),
        .flushAllInsns(flushAllInsns), .recoveryEntryNum(recoveryEntryNum)
    );

    assign recoveredPcCommit = faultRec.pc;
    assign exceptionOpPtr    = faultRec.ptr;

endmodule

// ==== rtl/commitView.sv ====
// =========================================================================
// Commit view
// Head read addresses, per-lane execution state for commit and the
// registered flush entry count for recovery
// =========================================================================
module commitView (
    input  logic                      clk,
    input  logic                      rstN,
    input  activeListPkg::alIndexT    headPtr,
    input  activeListPkg::alCountT    count,
    input  logic [0:0]                doneBits [activeListPkg::alCommitWidth],
    input  activeListPkg::faultRecT   faultRec,
    input  activeListPkg::alIndexT    flushRangeHeadPtr,
    input  activeListPkg::alIndexT    flushRangeTailPtr,
    input  logic                      toRecoveryPhase,
    output activeListPkg::alIndexT    headReadPtr [activeListPkg::alCommitWidth],
    output activeListPkg::execStateT  headExecState [activeListPkg::alCommitWidth],
    output logic                      flushAllInsns,
    output activeListPkg::alCountT    recoveryEntryNum
);

    activeListPkg::alIndexT flushDist;
    activeListPkg::alCountT flushNum;

    always_comb begin
        for (int i = 0; i < activeListPkg::alCommitWidth; i++) begin
            headReadPtr[i] = headPtr + activeListPkg::alIndexT'(i);
            // The fault record overrides the plain done bit
            if (faultRec.valid && headReadPtr[i] == faultRec.ptr) begin
                headExecState[i] = faultRec.state;
            end else if (doneBits[i][0]) begin
                headExecState[i] = activeListPkg::ExecSuccess;
            end else begin
                headExecState[i] = activeListPkg::ExecNotFinished;
            end
        end
    end

    always_comb begin
        flushDist = flushRangeTailPtr - flushRangeHeadPtr;
        // Count tells full from empty when the pointers are equal
        if (flushRangeHeadPtr == flushRangeTailPtr &&
                count == activeListPkg::alCountT'(activeListPkg::alEntryNum)) begin
            flushAllInsns = 1'b1;
            flushNum      = activeListPkg::alCountT'(activeListPkg::alEntryNum);
        end else begin
            flushAllInsns = 1'b0;
            flushNum      = activeListPkg::alCountT'(flushDist);
        end
    end

    // One cycle late for the rename committer
    always_ff @(posedge clk) begin
        if (!rstN) begin
            recoveryEntryNum <= '0;
        end else if (toRecoveryPhase) begin
            recoveryEntryNum <= flushNum;
        end
    end

endmodule

// ==== rtl/faultTracker.sv ====
// =========================================================================
// Fault tracker
// Keeps the oldest faulting completion relative to the head and decides
// whether recovery starts at writeback or waits for commit
// =========================================================================
module faultTracker (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic [activeListPkg::alIssueWidth-1:0] completeValid,
    input  activeListPkg::completionT      completeData [activeListPkg::alIssueWidth],
    input  activeListPkg::alIndexT         headPtr,
    input  logic                           toRecoveryPhase,
    input  logic                           unableToStartRecovery,
    output activeListPkg::faultRecT        faultRec,
    output logic                           exceptionDetected,
    output activeListPkg::refetchT         refetchType,
    output activeListPkg::pcT              recoveredPcWb
);

    activeListPkg::faultRecT  nextRec;
    activeListPkg::alIndexT   oldestAge;
    activeListPkg::alIndexT   laneAge;
    activeListPkg::execStateT laneState;
    logic                     refetchHit;
    logic                     recoverAtCommit;

    always_comb begin
        nextRec         = faultRec;
        oldestAge       = faultRec.ptr - headPtr;
        laneAge         = '0;
        laneState       = activeListPkg::ExecNotFinished;
        refetchHit      = 1'b0;
        recoverAtCommit = 1'b0;
        refetchType     = activeListPkg::RefetchThisPc;

        // Strict compare in lane order keeps the lower lane on a tie
        for (int i = 0; i < activeListPkg::alIssueWidth; i++) begin
            laneAge   = completeData[i].ptr - headPtr;
            laneState = completeData[i].state;
            if (completeValid[i] && !(laneState inside {activeListPkg::ExecNotFinished,
                                                        activeListPkg::ExecSuccess})) begin
                if (!nextRec.valid || laneAge < oldestAge) begin
                    oldestAge       = laneAge;
                    nextRec.valid   = 1'b1;
                    nextRec.ptr     = completeData[i].ptr;
                    nextRec.pc      = completeData[i].pc;
                    nextRec.state   = laneState;
                    refetchHit      = laneState inside {activeListPkg::ExecRefetchThis,
                                                        activeListPkg::ExecRefetchNext};
                    // Traps and faults touch CSRs, so they wait for commit
                    recoverAtCommit = laneState inside {activeListPkg::ExecTrap,
                                                        activeListPkg::ExecFault};
                    if (laneState == activeListPkg::ExecRefetchNext) begin
                        if (completeData[i].isBranch) begin
                            refetchType = activeListPkg::RefetchBranchTarget;
                        end else if (completeData[i].isStore) begin
                            refetchType = activeListPkg::RefetchStoreNextPc;
                        end else begin
                            refetchType = activeListPkg::RefetchNextPc;
                        end
                    end else begin
                        refetchType = activeListPkg::RefetchThisPc;
                    end
                end
            end
        end

        exceptionDetected = refetchHit && !unableToStartRecovery;
        // Commit must not restart a recovery that starts here
        if (exceptionDetected) begin
            nextRec.state = activeListPkg::ExecSuccess;
        end
        recoveredPcWb = nextRec.pc;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            faultRec <= '0;
        end else if (toRecoveryPhase && !exceptionDetected && !recoverAtCommit) begin
            faultRec <= '0;
        end else begin
            faultRec <= nextRec;
        end
    end

endmodule

// ==== rtl/alStorage.sv ====
// =========================================================================
// Active list storage
// Distributed array with several write ports and asynchronous head reads
// =========================================================================
module alStorage #(
    parameter int entryWidth = 1,
    parameter int writeNum   = 1
) (
    input  logic                   clk,
    input  logic [writeNum-1:0]    writeEn,
    input  activeListPkg::alIndexT writeAddr [writeNum],
    input  logic [entryWidth-1:0]  writeData [writeNum],
    input  activeListPkg::alIndexT readAddr [activeListPkg::alCommitWidth],
    output logic [entryWidth-1:0]  readData [activeListPkg::alCommitWidth]
);

    logic [entryWidth-1:0] mem [activeListPkg::alEntryNum];

    // Later ports override earlier ones on the same address
    always_ff @(posedge clk) begin
        for (int i = 0; i < writeNum; i++) begin
            if (writeEn[i]) begin
                mem[writeAddr[i]] <= writeData[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < activeListPkg::alCommitWidth; i++) begin
            readData[i] = mem[readAddr[i]];
        end
    end

endmodule

// ==== rtl/alPointers.sv ====
// =========================================================================
// Active list pointers
// Holds head, tail and occupancy, hands out compacted tail slots to the
// dispatch lanes and derives the allocation flags
// =========================================================================
module alPointers (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic [activeListPkg::alRenameWidth-1:0] pushTail,
    input  activeListPkg::laneCountT       popHeadNum,
    output activeListPkg::alIndexT         headPtr,
    output activeListPkg::alIndexT         pushedTailPtr [activeListPkg::alRenameWidth],
    output activeListPkg::alCountT         count,
    output logic                           allocatable,
    output logic                           empty,
    output activeListPkg::alIndexT         nextTailPtr
);

    activeListPkg::alIndexT   tailPtr;
    activeListPkg::laneCountT pushNum;

    always_comb begin
        pushNum = '0;
        // Each active lane takes the next free slot in lane order
        for (int i = 0; i < activeListPkg::alRenameWidth; i++) begin
            pushedTailPtr[i] = tailPtr + activeListPkg::alIndexT'(pushNum);
            pushNum += activeListPkg::laneCountT'(pushTail[i]);
        end
        nextTailPtr = tailPtr + activeListPkg::alIndexT'(pushNum);
    end

    // Room for a full dispatch group
    assign allocatable = count <= activeListPkg::alCountT'(activeListPkg::alEntryNum -
                                                           activeListPkg::alRenameWidth);
    assign empty = count == '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else begin
            // Index width matches the entry count, so wraparound is free
            headPtr <= headPtr + activeListPkg::alIndexT'(popHeadNum);
            tailPtr <= nextTailPtr;
            count   <= count + activeListPkg::alCountT'(pushNum)
                             - activeListPkg::alCountT'(popHeadNum);
        end
    end

endmodule

// ==== rtl/activeListPkg.sv ====
// =========================================================================
// Active list package
// Sizes, vector types, state encodings and payload structs shared by the
// reorder buffer blocks
// =========================================================================
package activeListPkg;

    // Buffer geometry and lane counts
    localparam int alEntryNum     = 16;
    localparam int alRenameWidth  = 2;
    localparam int alCommitWidth  = 2;
    localparam int alIssueWidth   = 3;
    // Done array takes dispatch clears plus completion sets
    localparam int alDoneWriteNum = alRenameWidth + alIssueWidth;

    typedef logic [$clog2(alEntryNum)-1:0] alIndexT;
    typedef logic [$clog2(alEntryNum):0]   alCountT;
    typedef logic [1:0]                    laneCountT;
    typedef logic [31:0]                   pcT;
    typedef logic [4:0]                    regNumT;

    // Completion state reported by the issue lanes
    typedef enum logic [2:0] {
        ExecNotFinished,
        ExecSuccess,
        ExecRefetchThis,
        ExecRefetchNext,
        ExecTrap,
        ExecFault
    } execStateT;

    // Restart point for fetch after a refetch
    typedef enum logic [1:0] {
        RefetchThisPc,
        RefetchNextPc,
        RefetchBranchTarget,
        RefetchStoreNextPc
    } refetchT;

    // Dispatch payload
    typedef struct packed {
        pcT     pc;
        regNumT destReg;
    } alEntryT;

    typedef struct packed {
        alIndexT   ptr;
        execStateT state;
        pcT        pc;
        logic      isBranch;
        logic      isStore;
    } completionT;

    // Oldest faulting op seen so far
    typedef struct packed {
        logic      valid;
        alIndexT   ptr;
        pcT        pc;
        execStateT state;
    } faultRecT;

endpackage
